/* hw/instDecode.sv */
// Instruction field decode stage
// Registered JRST 0 detect, coarse opcode class, and the
// indirect and indexed flags of the current IR

`timescale 1ns/1ps

module instDecode
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic [0:irPkg::irWidth-1]     regIr,
   output logic                          opJrst0,
   output irPkg::opClassT                opClass,
   output logic                          irIndirect,
   output logic                          irIndexed
);

   // Field positions within the IR
   localparam int opLast   = irPkg::opWidth - 1;
   localparam int acFirst  = irPkg::opWidth;
   localparam int acLast   = irPkg::irLeftWidth - 1;
   localparam int indBit   = irPkg::irLeftWidth;
   localparam int xrFirst  = irPkg::irLeftWidth + 1;
   localparam int xrLast   = irPkg::irWidth - 1;

   //////////////////////////////////////////////////////////////////////
   // Field split
   //////////////////////////////////////////////////////////////////////

   logic [0:irPkg::opWidth-1] opField;
   logic [0:irPkg::acWidth-1] acField;
   logic                      indField;
   logic [0:irPkg::xrWidth-1] xrField;

   assign opField  = regIr[0:opLast];
   assign acField  = regIr[acFirst:acLast];
   assign indField = regIr[indBit];
   assign xrField  = regIr[xrFirst:xrLast];

   //////////////////////////////////////////////////////////////////////
   // Combinational decode
   //////////////////////////////////////////////////////////////////////

   logic           jrst0Next;
   irPkg::opClassT classNext;

   // JRST with AC 0 is the plain jump
   assign jrst0Next = (opField == irPkg::opJrst) && (acField == '0);

   // Class ranges from the package, jump range includes JRST
   always_comb
   begin
      classNext = irPkg::opClassOther;
      if ((opField >= irPkg::opMoveFirst) && (opField <= irPkg::opMoveLast))
      begin
         classNext = irPkg::opClassMove;
      end
      else if ((opField >= irPkg::opJumpFirst) && (opField <= irPkg::opJumpLast))
      begin
         classNext = irPkg::opClassJump;
      end
      else if ((opField >= irPkg::opArithFirst) && (opField <= irPkg::opArithLast))
      begin
         classNext = irPkg::opClassArith;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stage 3 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         opJrst0    <= 1'b0;
         opClass    <= irPkg::opClassOther;
         irIndirect <= 1'b0;
         irIndexed  <= 1'b0;
      end
      else
      begin
         opJrst0    <= jrst0Next;
         opClass    <= classNext;
         irIndirect <= indField;
         irIndexed  <= (xrField != '0);   // any index register but 0
      end
   end

endmodule

/* hw/instRegister.sv */
// Instruction register stage
// Split-loadable IR: opcode and AC on one strobe, indirect and index
// on the other; keeps the previous-context bit and flags full loads

`timescale 1ns/1ps

module instRegister
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          loadIr,
   input  logic                          loadXr,
   input  logic [0:irPkg::irWidth-1]     busQ,
   input  logic                          prevQ,
   output logic [0:irPkg::irWidth-1]     regIr,
   output logic                          xrPrev,
   output logic                          regsLoad
);

   // Half boundaries
   localparam int leftLast   = irPkg::irLeftWidth - 1;
   localparam int rightFirst = irPkg::irLeftWidth;
   localparam int rightLast  = irPkg::irWidth - 1;

   //////////////////////////////////////////////////////////////////////
   // Instruction register
   //////////////////////////////////////////////////////////////////////

   // Both halves may load on the same edge
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         regIr <= '0;
      end
      else
      begin
         // Opcode and AC
         if (loadIr)
         begin
            regIr[0:leftLast] <= busQ[0:leftLast];
         end
         // Indirect bit and index
         if (loadXr)
         begin
            regIr[rightFirst:rightLast] <= busQ[rightFirst:rightLast];
         end
      end
   end

   // Previous context, follows the index half
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         xrPrev <= 1'b0;
      end
      else if (loadXr)
      begin
         xrPrev <= prevQ;
      end
   end

   // Full instruction loaded, used by the trace stage
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         regsLoad <= 1'b0;
      end
      else
      begin
         regsLoad <= loadIr && loadXr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // No full-load flag without both strobes the cycle before
   aRegsLoad : assert property (@(posedge clk) disable iff (rst)
         regsLoad |-> $past(loadIr && loadXr))
      else $error("instRegister: regsLoad without a combined load");

endmodule

/* hw/irPkg.sv */
// Instruction register package
// Field widths, microword special-function selector, opcode classes
// and the opcode constants shared by the IR slice

package irPkg;

   //////////////////////////////////////////////////////////////////////
   // Field widths
   //////////////////////////////////////////////////////////////////////

   // Data bus, full 36-bit word
   parameter int busWidth = 36;

   // Instruction register, left half of the word
   parameter int irWidth = 18;

   // Opcode and accumulator fields
   parameter int opWidth = 9;
   parameter int acWidth = 4;

   // Index field, follows the indirect bit
   parameter int xrWidth = 4;

   // Left part of the IR, loaded by the IR strobe
   parameter int irLeftWidth = opWidth + acWidth;

   //////////////////////////////////////////////////////////////////////
   // Enumerations
   //////////////////////////////////////////////////////////////////////

   // Microword special-function selector
   typedef enum logic [3:0] {
      specNone     = 4'd0,
      specLoadIr   = 4'd1,
      specLoadXr   = 4'd2,
      specLoadIrXr = 4'd3,
      specOther    = 4'd4
   } specSelT;

   // Coarse opcode class
   typedef enum logic [2:0] {
      opClassOther = 3'd0,
      opClassMove  = 3'd1,
      opClassArith = 3'd2,
      opClassJump  = 3'd3
   } opClassT;

   //////////////////////////////////////////////////////////////////////
   // Opcode constants
   //////////////////////////////////////////////////////////////////////

   parameter logic [0:opWidth-1] opJrst = 9'o254;

   // Class ranges, inclusive
   parameter logic [0:opWidth-1] opMoveFirst  = 9'o200;
   parameter logic [0:opWidth-1] opMoveLast   = 9'o217;
   parameter logic [0:opWidth-1] opJumpFirst  = 9'o250;
   parameter logic [0:opWidth-1] opJumpLast   = 9'o267;
   parameter logic [0:opWidth-1] opArithFirst = 9'o270;
   parameter logic [0:opWidth-1] opArithLast  = 9'o277;

endpackage

/* hw/irTrace.sv */
// Instruction trace capture
// Records each fully loaded instruction with its context bit and
// keeps a wrapping count of recorded instructions

`timescale 1ns/1ps

module irTrace
#(
   parameter int countWidth = 8
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          regsLoad,
   input  logic [0:irPkg::irWidth-1]     regIr,
   input  logic                          xrPrev,
   output logic                          traceValid,
   output logic [0:irPkg::irWidth-1]     traceIr,
   output logic                          traceXrPrev,
   output logic [countWidth-1:0]         traceCount
);

   //////////////////////////////////////////////////////////////////////
   // Capture register
   //////////////////////////////////////////////////////////////////////

   // Record held until the next full load
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         traceIr     <= '0;
         traceXrPrev <= 1'b0;
      end
      else if (regsLoad)
      begin
         traceIr     <= regIr;
         traceXrPrev <= xrPrev;
      end
   end

   // One-cycle valid pulse and running count
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         traceValid <= 1'b0;
         traceCount <= '0;
      end
      else
      begin
         traceValid <= regsLoad;
         if (regsLoad)
         begin
            // Wraps naturally at the counter width
            traceCount <= traceCount + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Valid pulse lags the full load by exactly one cycle
   aTraceValid : assert property (@(posedge clk) disable iff (rst)
         traceValid == $past(regsLoad))
      else $error("irTrace: traceValid out of step with regsLoad");

endmodule

/* hw/irUnit.sv */
// Instruction register unit
// Microword decode, split-loaded IR, field decode and trace capture
// joined into a three-stage pipeline

`timescale 1ns/1ps

module irUnit
#(
   parameter int countWidth = 8
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  irPkg::specSelT                specSel,
   input  logic                          specEn40,
   input  logic                          specEn20,
   input  logic [0:irPkg::busWidth-1]    dbus,
   input  logic                          prevEn,
   output logic [0:irPkg::irWidth-1]     regIr,
   output logic                          xrPrev,
   output logic                          opJrst0,
   output irPkg::opClassT                opClass,
   output logic                          irIndirect,
   output logic                          irIndexed,
   output logic                          traceValid,
   output logic [0:irPkg::irWidth-1]     traceIr,
   output logic                          traceXrPrev,
   output logic [countWidth-1:0]         traceCount
);

   // Stage 1 to stage 2
   logic                      loadIr;
   logic                      loadXr;
   logic                      prevQ;
   logic [0:irPkg::irWidth-1] busQ;

   // Stage 2 to trace
   logic regsLoad;

   //////////////////////////////////////////////////////////////////////
   // Pipeline stages
   //////////////////////////////////////////////////////////////////////

   specDecode specDecode0 (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .specSel  (specSel),
      .specEn40 (specEn40),
      .specEn20 (specEn20),
      .dbus     (dbus),
      .prevEn   (prevEn),
      .loadIr   (loadIr),
      .loadXr   (loadXr),
      .prevQ    (prevQ),
      .busQ     (busQ)
   );

   instRegister instRegister0 (
      .clk      (clk),
      .rst      (rst),
      .loadIr   (loadIr),
      .loadXr   (loadXr),
      .busQ     (busQ),
      .prevQ    (prevQ),
      .regIr    (regIr),
      .xrPrev   (xrPrev),
      .regsLoad (regsLoad)
   );

   // Decode and trace both read stage 2 in parallel
   instDecode instDecode0 (
      .clk        (clk),
      .rst        (rst),
      .regIr      (regIr),
      .opJrst0    (opJrst0),
      .opClass    (opClass),
      .irIndirect (irIndirect),
      .irIndexed  (irIndexed)
   );

   irTrace #(
      .countWidth (countWidth)
   ) irTrace0 (
      .clk         (clk),
      .rst         (rst),
      .regsLoad    (regsLoad),
      .regIr       (regIr),
      .xrPrev      (xrPrev),
      .traceValid  (traceValid),
      .traceIr     (traceIr),
      .traceXrPrev (traceXrPrev),
      .traceCount  (traceCount)
   );

endmodule

/* hw/specDecode.sv */
// Special-function decode stage
// Turns the microword special field into IR load strobes, gated by
// the clock enable, and registers them with the bus bits they load

`timescale 1ns/1ps

module specDecode
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  irPkg::specSelT                specSel,
   input  logic                          specEn40,
   input  logic                          specEn20,
   input  logic [0:irPkg::busWidth-1]    dbus,
   input  logic                          prevEn,
   output logic                          loadIr,
   output logic                          loadXr,
   output logic                          prevQ,
   output logic [0:irPkg::irWidth-1]     busQ
);

   // Selector matches, either half alone or both together
   logic selIr;
   logic selXr;

   // Strobes before the register
   logic loadIrNext;
   logic loadXrNext;

   assign selIr = (specSel == irPkg::specLoadIr) || (specSel == irPkg::specLoadIrXr);
   assign selXr = (specSel == irPkg::specLoadXr) || (specSel == irPkg::specLoadIrXr);

   // Clock enable folded in here only
   assign loadIrNext = clken && specEn40 && selIr;
   assign loadXrNext = clken && specEn20 && selXr;

   //////////////////////////////////////////////////////////////////////
   // Stage 1 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         loadIr <= 1'b0;
         loadXr <= 1'b0;
         prevQ  <= 1'b0;
         busQ   <= '0;
      end
      else
      begin
         loadIr <= loadIrNext;
         loadXr <= loadXrNext;
         // Only the left half of the word reaches the IR
         busQ   <= dbus[0:irPkg::irWidth-1];
         prevQ  <= prevEn;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Combined selector with both enables loads both halves
   property pBothStrobes;
      @(posedge clk) disable iff (rst)
         (clken && specEn40 && specEn20 && specSel == irPkg::specLoadIrXr)
            |=> (loadIr && loadXr);
   endproperty

   aBothStrobes : assert property (pBothStrobes)
      else $error("specDecode: combined load did not raise both strobes");

endmodule

/* irUnit.f */
hw/irPkg.sv
hw/specDecode.sv
hw/instRegister.sv
hw/instDecode.sv
hw/irTrace.sv
hw/irUnit.sv
verif/irUnitTb.sv

/* verif/irUnitCases.txt */
# rst clken specSel en40 en20 dbus(octal) prevEn | regIr(octal) xrPrev opJrst0 opClass
# irIndirect irIndexed trace traceCount; specSel 0 none 1 ir 2 xr 3 irxr 4 other
# opClass 0 other 1 move 2 arith 3 jump
0 1 3 1 1 200037123456 1   200037 1 0 1 1 1 1 1
0 1 1 1 0 254000000000 0   254037 1 1 3 1 1 0 1
0 1 2 0 1 777000000000 0   254000 0 1 3 0 0 0 1
0 1 2 0 1 000025000000 1   254025 1 1 3 1 1 0 1
0 1 2 0 1 000000777777 0   254000 0 1 3 0 0 0 1
0 1 2 0 1 000020000000 1   254020 1 1 3 1 0 0 1
0 1 2 0 1 000007000000 0   254007 0 1 3 0 1 0 1
0 0 3 1 1 123456654321 1   254007 0 1 3 0 1 0 1
0 1 1 0 1 777777777777 1   254007 0 1 3 0 1 0 1
0 1 2 1 0 777777777777 1   254007 0 1 3 0 1 0 1
0 1 4 1 1 777777777777 1   254007 0 1 3 0 1 0 1
0 1 0 1 1 777777777777 1   254007 0 1 3 0 1 0 1
0 1 3 1 1 254040000000 0   254040 0 0 3 0 0 1 2
0 1 3 1 1 275123000000 1   275123 1 0 2 1 1 1 3
0 1 3 1 1 100000000000 0   100000 0 0 0 0 0 1 4
0 1 3 1 1 217377000000 1   217377 1 0 1 1 1 1 5
0 1 3 1 1 250000000000 0   250000 0 0 3 0 0 1 6
0 1 3 1 1 267000000000 0   267000 0 0 3 0 0 1 7
0 1 3 1 1 270000000000 0   270000 0 0 2 0 0 1 8
0 1 3 1 1 277000000000 0   277000 0 0 2 0 0 1 9
0 1 3 1 1 220000000000 0   220000 0 0 0 0 0 1 10
0 1 3 1 1 247000000000 0   247000 0 0 0 0 0 1 11
0 1 3 1 1 300000000000 0   300000 0 0 0 0 0 1 12
0 1 3 1 1 254003000000 1   254003 1 1 3 0 1 1 13
1 1 3 1 1 275000000000 1   000000 0 0 0 0 0 0 0
0 1 3 1 1 254000000000 0   254000 0 1 3 0 0 1 1
0 1 1 1 0 200000000000 1   200000 0 0 1 0 0 0 1
0 0 2 0 1 000037000000 1   200000 0 0 1 0 0 0 1

/* verif/irUnitTb.sv */
// IR unit testbench
// Reads stimulus and expected results from the cases file, runs each
// case through the pipeline and checks IR, decode and trace outputs

`timescale 1ns/1ps

module irUnitTb;

   localparam int maxCases    = 64;
   localparam int resetCycles = 10;
   localparam int caseBudget  = 10;

   // DUT ports
   logic                        clk;
   logic                        rst;
   logic                        clken;
   irPkg::specSelT              specSel;
   logic                        specEn40;
   logic                        specEn20;
   logic [0:irPkg::busWidth-1]  dbus;
   logic                        prevEn;
   logic [0:irPkg::irWidth-1]   regIr;
   logic                        xrPrev;
   logic                        opJrst0;
   irPkg::opClassT              opClass;
   logic                        irIndirect;
   logic                        irIndexed;
   logic                        traceValid;
   logic [0:irPkg::irWidth-1]   traceIr;
   logic                        traceXrPrev;
   logic [7:0]                  traceCount;

   // Case table, one entry per data line
   int          caseRst     [0:maxCases-1];
   int          caseClken   [0:maxCases-1];
   logic [3:0]  caseSel     [0:maxCases-1];
   int          caseEn40    [0:maxCases-1];
   int          caseEn20    [0:maxCases-1];
   logic [35:0] caseBus     [0:maxCases-1];
   int          casePrev    [0:maxCases-1];
   logic [17:0] caseIr      [0:maxCases-1];
   int          caseXrPrev  [0:maxCases-1];
   int          caseJrst0   [0:maxCases-1];
   int          caseClass   [0:maxCases-1];
   int          caseInd     [0:maxCases-1];
   int          caseIdx     [0:maxCases-1];
   int          caseTrace   [0:maxCases-1];
   int          caseCount   [0:maxCases-1];

   int   numCases;
   int   curCase;
   int   errCount;
   int   passCount;
   int   failCount;
   logic casesLoaded;

   // Expected trace record, kept across cases
   logic [17:0] modelTraceIr;
   logic        modelTraceXrPrev;

   irUnit #(
      .countWidth (8)
   ) dut0 (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .specSel     (specSel),
      .specEn40    (specEn40),
      .specEn20    (specEn20),
      .dbus        (dbus),
      .prevEn      (prevEn),
      .regIr       (regIr),
      .xrPrev      (xrPrev),
      .opJrst0     (opJrst0),
      .opClass     (opClass),
      .irIndirect  (irIndirect),
      .irIndexed   (irIndexed),
      .traceValid  (traceValid),
      .traceIr     (traceIr),
      .traceXrPrev (traceXrPrev),
      .traceCount  (traceCount)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // Parse the cases file, skipping comment lines
   task automatic loadCases();
      int          fd;
      int          n;
      string       line;
      int          r, c, e4, e2, p, xp, j, cl, ind, idx, tr, cnt;
      logic [3:0]  s;
      logic [35:0] bus;
      logic [17:0] ir;
      begin
         fd = $fopen("verif/irUnitCases.txt", "r");
         if (fd == 0)
         begin
            $display("Could not open the cases file verif/irUnitCases.txt");
            errCount++;
         end
         else
         begin
            while (!$feof(fd) && numCases < maxCases)
            begin
               line = "";
               if ($fgets(line, fd) == 0)
               begin
                  break;
               end
               if (line.len() <= 1 || line.getc(0) == "#")
               begin
                  continue;
               end
               n = $sscanf(line, "%d %d %d %d %d %o %d %o %d %d %d %d %d %d %d",
                           r, c, s, e4, e2, bus, p, ir, xp, j, cl, ind, idx, tr, cnt);
               if (n != 15)
               begin
                  $display("Malformed line in the cases file: %s", line);
                  errCount++;
                  continue;
               end
               caseRst[numCases]    = r;
               caseClken[numCases]  = c;
               caseSel[numCases]    = s;
               caseEn40[numCases]   = e4;
               caseEn20[numCases]   = e2;
               caseBus[numCases]    = bus;
               casePrev[numCases]   = p;
               caseIr[numCases]     = ir;
               caseXrPrev[numCases] = xp;
               caseJrst0[numCases]  = j;
               caseClass[numCases]  = cl;
               caseInd[numCases]    = ind;
               caseIdx[numCases]    = idx;
               caseTrace[numCases]  = tr;
               caseCount[numCases]  = cnt;
               numCases++;
            end
            $fclose(fd);
         end
      end
   endtask

   // Compare and report a mismatch
   task automatic checkValue(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
      begin
         if (got !== exp)
         begin
            errCount++;
            $display("ERR at %0d ns: case %0d %s is %0o, expected %0o",
                     $time, curCase, what, got, exp);
         end
      end
   endtask

   // Drive one case for a cycle, then follow it down the pipeline
   task automatic runCase(input int k);
      int errsBefore;
      begin
         errsBefore = errCount;
         curCase    = k;
         @(posedge clk);
         rst      <= (caseRst[k] != 0);
         clken    <= (caseClken[k] != 0);
         specSel  <= irPkg::specSelT'(caseSel[k]);
         specEn40 <= (caseEn40[k] != 0);
         specEn20 <= (caseEn20[k] != 0);
         dbus     <= caseBus[k];
         prevEn   <= (casePrev[k] != 0);
         // Held for one cycle, then back to idle
         @(posedge clk);
         rst      <= 1'b0;
         clken    <= 1'b1;
         specSel  <= irPkg::specNone;
         specEn40 <= 1'b0;
         specEn20 <= 1'b0;
         dbus     <= '0;
         prevEn   <= 1'b0;
         // Reset clears the record, a full load replaces it
         if (caseRst[k] != 0)
         begin
            modelTraceIr     = '0;
            modelTraceXrPrev = 1'b0;
         end
         else if (caseTrace[k] != 0)
         begin
            modelTraceIr     = caseIr[k];
            modelTraceXrPrev = (caseXrPrev[k] != 0);
         end
         // IR two cycles after the sampling edge
         @(posedge clk);
         @(negedge clk);
         checkValue(regIr, caseIr[k], "regIr");
         checkValue(xrPrev, caseXrPrev[k], "xrPrev");
         // Decode and trace one cycle later
         @(posedge clk);
         @(negedge clk);
         checkValue(opJrst0, caseJrst0[k], "opJrst0");
         checkValue(opClass, caseClass[k], "opClass");
         checkValue(irIndirect, caseInd[k], "irIndirect");
         checkValue(irIndexed, caseIdx[k], "irIndexed");
         checkValue(traceValid, caseTrace[k], "traceValid");
         checkValue(traceIr, modelTraceIr, "traceIr");
         checkValue(traceXrPrev, modelTraceXrPrev, "traceXrPrev");
         checkValue(traceCount, caseCount[k], "traceCount");
         // Pulse must be one cycle wide
         @(posedge clk);
         @(negedge clk);
         checkValue(traceValid, 0, "traceValid after pulse");
         if (errCount == errsBefore)
         begin
            passCount++;
            $display("case %0d: pass", k);
         end
         else
         begin
            failCount++;
            $display("case %0d: %0d mismatches", k, errCount - errsBefore);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      rst              = 1'b1;
      clken            = 1'b0;
      specSel          = irPkg::specNone;
      specEn40         = 1'b0;
      specEn20         = 1'b0;
      dbus             = '0;
      prevEn           = 1'b0;
      errCount         = 0;
      passCount        = 0;
      failCount        = 0;
      numCases         = 0;
      curCase          = 0;
      modelTraceIr     = '0;
      modelTraceXrPrev = 1'b0;
      casesLoaded      = 1'b0;
      loadCases();
      casesLoaded = 1'b1;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      for (int k = 0; k < numCases; k++)
      begin
         runCase(k);
      end
      $display("Cases %0d, passed %0d, failed %0d, errors %0d",
               numCases, passCount, failCount, errCount);
      if (errCount == 0 && numCases > 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Budget of ten cycles per case plus reset
   initial
   begin
      wait (casesLoaded);
      repeat (resetCycles + numCases * caseBudget + caseBudget) @(posedge clk);
      $display("Timeout: the run did not finish within its cycle budget");
      $display("TEST FAILED");
      $finish;
   end

endmodule
